// ==== tb.f ====
db_pkg.sv
db_store.sv
db_wr_cache.sv
db_prio_mux.sv
db_ctrl.sv
db_top.sv
tb_clk_gen.sv
tb_db_top.sv

// ==== tb_db_top.sv ====
/* Directed testbench of db_top with a per-key reference model and fixed-latency checks
   Concurrent control and data traffic use disjoint keys, so model order stays exact
   Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge */
`timescale 1ns/1ps
`default_nettype none

module tb_db_top import db_pkg::*; ();

    // Test lengths in cycles plus two full table sweeps
    localparam int timeout_cycles = 40 + 60 + 40 + 120 + 400 + 200 + 2 * tbl_depth;
    // Uncontested data-plane ack latencies at the top level
    localparam int wr_ack_lat = 3;
    localparam int rd_ack_lat = 5;

    logic      clk;
    logic      srst;
    logic      ctrl_cmd_valid;
    ctrl_cmd_t ctrl_cmd;
    logic      ctrl_busy;
    logic      ctrl_done;
    db_rsp_t   ctrl_rsp;
    logic      init_done;
    logic      app_wr_req;
    logic      app_wr_rdy;
    db_req_t   app_wr_data;
    logic      app_wr_ack;
    logic      app_rd_req;
    logic      app_rd_rdy;
    key_t      app_rd_key;
    logic      app_rd_ack;
    db_rsp_t   app_rd_rsp;

    // Reference table, one entry per key
    db_rsp_t     model [tbl_depth];
    // Accept cycles and expected results of outstanding transactions
    int          wr_cyc_q [$];
    int          rd_cyc_q [$];
    db_rsp_t     rd_exp_q [$];
    logic        ctrl_get_q [$];
    db_rsp_t     ctrl_exp_q [$];
    int          cycle = 0;
    logic [31:0] rng;

    tb_clk_gen u_clk_gen (.clk (clk), .srst (srst));

    db_top DUT (
        .clk (clk), .srst (srst),
        .ctrl_cmd_valid (ctrl_cmd_valid), .ctrl_cmd (ctrl_cmd),
        .ctrl_busy (ctrl_busy), .ctrl_done (ctrl_done), .ctrl_rsp (ctrl_rsp),
        .init_done (init_done),
        .app_wr_req (app_wr_req), .app_wr_rdy (app_wr_rdy),
        .app_wr_data (app_wr_data), .app_wr_ack (app_wr_ack),
        .app_rd_req (app_rd_req), .app_rd_rdy (app_rd_rdy), .app_rd_key (app_rd_key),
        .app_rd_ack (app_rd_ack), .app_rd_rsp (app_rd_rsp)
    );

    // 32-bit xorshift, state kept in rng
    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // Value of a deleted entry carries no meaning
    function automatic logic rsp_ok(input db_rsp_t got, input db_rsp_t exp);
        return (got.present == exp.present) && (!exp.present || (got.value == exp.value));
    endfunction

    task automatic abort_run;
        $display("Checks failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    // --------------------------------------------------
    // Response monitor
    // --------------------------------------------------
    task automatic check_wr_ack;
        int lat;
        assert (wr_cyc_q.size() > 0) else begin
            $display("app_wr_ack pulsed with no write outstanding");
            abort_run();
        end
        lat = cycle - wr_cyc_q.pop_front();
        assert (lat == wr_ack_lat) else begin
            $display("** Error: app_wr_ack latency %h, expected %h", lat, wr_ack_lat);
            abort_run();
        end
    endtask

    task automatic check_rd_ack;
        int      lat;
        db_rsp_t exp;
        assert (rd_cyc_q.size() > 0) else begin
            $display("app_rd_ack pulsed with no read outstanding");
            abort_run();
        end
        lat = cycle - rd_cyc_q.pop_front();
        exp = rd_exp_q.pop_front();
        assert (lat == rd_ack_lat) else begin
            $display("** Error: app_rd_ack latency %h, expected %h", lat, rd_ack_lat);
            abort_run();
        end
        assert (rsp_ok(app_rd_rsp, exp)) else begin
            $display("** Error: app_rd_rsp present %h value %h, expected present %h value %h",
                     app_rd_rsp.present, app_rd_rsp.value, exp.present, exp.value);
            abort_run();
        end
    endtask

    task automatic check_ctrl_done;
        logic    is_get;
        db_rsp_t exp;
        assert (ctrl_get_q.size() > 0) else begin
            $display("ctrl_done pulsed with no command outstanding");
            abort_run();
        end
        is_get = ctrl_get_q.pop_front();
        exp    = ctrl_exp_q.pop_front();
        if (is_get) begin
            assert (rsp_ok(ctrl_rsp, exp)) else begin
                $display("** Error: ctrl_rsp present %h value %h, expected present %h value %h",
                         ctrl_rsp.present, ctrl_rsp.value, exp.present, exp.value);
                abort_run();
            end
        end
    endtask

    // A read accepted with a write sees the old entry
    always @(negedge clk) begin
        if (!srst) begin
            if (app_rd_req && app_rd_rdy) begin
                rd_exp_q.push_back(model[app_rd_key]);
                rd_cyc_q.push_back(cycle);
            end
            if (app_wr_req && app_wr_rdy) begin
                model[app_wr_data.key] = '{present: app_wr_data.present,
                                           value: app_wr_data.value};
                wr_cyc_q.push_back(cycle);
            end
            if (app_wr_ack) check_wr_ack();
            if (app_rd_ack) check_rd_ack();
            if (ctrl_done) check_ctrl_done();
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > timeout_cycles) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------
    // Holds each data-plane request until accepted; a control strobe lasts one cycle
    task automatic drive_cycle(input logic do_wr, input db_req_t wdata,
                               input logic do_rd, input key_t rkey);
        logic wr_pend;
        logic rd_pend;
        wr_pend     = do_wr;
        rd_pend     = do_rd;
        app_wr_req  = do_wr;
        app_wr_data = wdata;
        app_rd_req  = do_rd;
        app_rd_key  = rkey;
        do begin
            @(negedge clk);
            if (app_wr_rdy) wr_pend = 1'b0;
            if (app_rd_rdy) rd_pend = 1'b0;
            @(posedge clk);
            #1;
            ctrl_cmd_valid = 1'b0;
            app_wr_req     = wr_pend;
            app_rd_req     = rd_pend;
        end while (wr_pend || rd_pend);
    endtask

    task automatic write_key(input key_t key, input logic present, input value_t value);
        db_req_t w;
        w.key     = key;
        w.value   = value;
        w.present = present;
        drive_cycle(1'b1, w, 1'b0, '0);
    endtask

    task automatic read_key(input key_t key);
        drive_cycle(1'b0, '0, 1'b1, key);
    endtask

    // Waits for every outstanding response and an idle control FSM
    task automatic wait_idle;
        while (wr_cyc_q.size() != 0 || rd_cyc_q.size() != 0 ||
               ctrl_get_q.size() != 0 || ctrl_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Presents a command in the current cycle and updates the model at issue
    task automatic send_cmd(input ctrl_op_e op, input key_t key, input value_t value);
        while (ctrl_busy) begin
            @(posedge clk);
            #1;
        end
        ctrl_cmd_valid = 1'b1;
        ctrl_cmd.op    = op;
        ctrl_cmd.key   = key;
        ctrl_cmd.value = value;
        case (op)
            CMD_SET:  model[key] = '{present: 1'b1, value: value};
            CMD_DEL:  model[key] = '{present: 1'b0, value: value};
            CMD_INIT: for (int i = 0; i < tbl_depth; i++) model[i] = '0;
            default:  ;
        endcase
        // INIT ends on init_done, every other command on ctrl_done
        if (op != CMD_INIT) begin
            ctrl_get_q.push_back(op == CMD_GET);
            ctrl_exp_q.push_back(model[key]);
        end
    endtask

    task automatic run_cmd(input ctrl_op_e op, input key_t key, input value_t value);
        send_cmd(op, key, value);
        drive_cycle(1'b0, '0, 1'b0, '0);
        wait_idle();
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_clear;
        logic [31:0] r;
        repeat (2) @(posedge clk);
        @(negedge clk);
        // Sweep is running, so both data-plane ports are back-pressured
        assert (!app_wr_ack && !app_rd_ack && !ctrl_done && !init_done && ctrl_busy &&
                !app_wr_rdy && !app_rd_rdy) else begin
            $display("Outputs were not in their reset state after reset");
            abort_run();
        end
        @(posedge clk);
        #1;
        wait_idle();
        assert (init_done) else begin
            $display("init_done was low once the control FSM went idle after reset");
            abort_run();
        end
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            run_cmd(CMD_GET, r[7:0], '0);
        end
    endtask

    task automatic test_write_read;
        logic [31:0] r;
        key_t        keys [8];
        for (int i = 0; i < 8; i++) begin
            r       = next_rand();
            keys[i] = r[7:0];
            write_key(keys[i], 1'b1, r[31:16]);
        end
        for (int i = 0; i < 8; i++) read_key(keys[i]);
        wait_idle();
    endtask

    // Store still holds the old entry when the read is accepted
    task automatic test_read_after_write;
        logic [31:0] r;
        r = next_rand();
        write_key(r[7:0], 1'b1, ~r[31:16]);
        wait_idle();
        write_key(r[7:0], 1'b1, r[31:16]);
        read_key(r[7:0]);
        write_key(r[7:0], 1'b0, r[23:8]);
        read_key(r[7:0]);
        wait_idle();
    endtask

    task automatic test_ctrl_priority;
        logic [31:0] r;
        key_t        key;
        r   = next_rand();
        key = r[7:0];
        run_cmd(CMD_SET, key, r[31:16]);
        run_cmd(CMD_GET, key, '0);
        run_cmd(CMD_DEL, key, '0);
        run_cmd(CMD_GET, key, '0);
        read_key(key);
        run_cmd(CMD_SET, key, ~r[31:16]);
        // GET goes out with the first of 20 back-to-back reads of another key
        send_cmd(CMD_GET, key, '0);
        for (int i = 0; i < 20; i++) read_key(key ^ 8'h01);
        assert (ctrl_get_q.size() == 1) else begin
            $display("Control GET completed while the data plane was still reading");
            abort_run();
        end
        wait_idle();
    endtask

    // Data plane on keys 0x40..0x47, control plane on 0x80..0x83
    task automatic test_mixed;
        logic [31:0] r;
        int          ops;
        db_req_t     w;
        logic        do_wr;
        logic        do_rd;
        ctrl_op_e    op;
        ops = 0;
        while (ops < 200) begin
            r = next_rand();
            if (!ctrl_busy) begin
                case (r[9:8])
                    2'd0:    op = CMD_GET;
                    2'd1:    op = CMD_SET;
                    default: op = CMD_DEL;
                endcase
                send_cmd(op, {6'b100000, r[11:10]}, r[31:16]);
            end
            w.key     = {5'b01000, r[2:0]};
            w.value   = r[27:12];
            w.present = r[3] | r[4];
            do_wr     = r[5];
            do_rd     = r[6] | !r[5];
            drive_cycle(do_wr, w, do_rd, {5'b01000, r[14:12]});
            ops = ops + do_wr + do_rd;
        end
        wait_idle();
    endtask

    task automatic test_init_clear;
        logic [31:0] r;
        key_t        keys [4];
        for (int i = 0; i < 4; i++) begin
            r       = next_rand();
            keys[i] = r[7:0];
            write_key(keys[i], 1'b1, r[31:16]);
        end
        wait_idle();
        send_cmd(CMD_INIT, '0, '0);
        drive_cycle(1'b0, '0, 1'b0, '0);
        repeat (2) @(posedge clk);
        #1;
        assert (!init_done) else begin
            $display("init_done stayed high after an INIT command");
            abort_run();
        end
        wait_idle();
        assert (init_done) else begin
            $display("init_done was low once INIT had completed");
            abort_run();
        end
        // Entries written just before INIT, still held in the write cache
        for (int i = 0; i < 4; i++) begin
            run_cmd(CMD_GET, keys[i], '0);
            read_key(keys[i]);
        end
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            run_cmd(CMD_GET, r[7:0], '0);
            read_key(r[15:8]);
        end
        wait_idle();
    endtask

    initial begin
        ctrl_cmd_valid = 1'b0;
        ctrl_cmd       = '0;
        app_wr_req     = 1'b0;
        app_wr_data    = '0;
        app_rd_req     = 1'b0;
        app_rd_key     = '0;
        rng            = 32'd73;
        for (int i = 0; i < tbl_depth; i++) model[i] = '0;

        test_reset_clear();
        test_write_read();
        test_read_after_write();
        test_ctrl_priority();
        test_mixed();
        test_init_clear();

        if (wr_cyc_q.size() == 0 && rd_cyc_q.size() == 0 && ctrl_get_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Responses were still outstanding at the end of the run");
            $display("Checks failed");
            $fatal(1, "Run ended with outstanding responses");
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
/* Free-running 100 ns clock for the testbench
   srst is high through the first two rising edges and drops 1 ns after the second */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic srst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Released like any other driven input, just after an edge
    initial begin
        srst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        srst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== db_top.sv ====
/* Key-value table with a data-plane port and a control port; the data plane has priority
   Uncontested data-plane writes ack after 3 cycles and reads after 5 */
`timescale 1ns/1ps
`default_nettype none

module db_top import db_pkg::*; (
    input  logic      clk,
    input  logic      srst,
    // Control port
    input  logic      ctrl_cmd_valid,
    input  ctrl_cmd_t ctrl_cmd,
    output logic      ctrl_busy,
    output logic      ctrl_done,
    output db_rsp_t   ctrl_rsp,
    output logic      init_done,
    // Data-plane write
    input  logic      app_wr_req,
    output logic      app_wr_rdy,
    input  db_req_t   app_wr_data,
    output logic      app_wr_ack,
    // Data-plane read
    input  logic      app_rd_req,
    output logic      app_rd_rdy,
    input  key_t      app_rd_key,
    output logic      app_rd_ack,
    output db_rsp_t   app_rd_rsp
);

    logic    db_init;
    logic    db_init_done;
    db_req_t app_rd_data;

    // Control side of both muxes
    logic    ctrl_wr_req, ctrl_wr_rdy, ctrl_wr_ack;
    logic    ctrl_rd_req, ctrl_rd_rdy, ctrl_rd_ack;
    db_req_t ctrl_wr_data, ctrl_rd_data;
    db_rsp_t ctrl_rd_rsp;

    // Store side
    logic    st_wr_req, st_wr_rdy, st_wr_ack;
    logic    st_rd_req, st_rd_rdy, st_rd_ack;
    db_req_t st_wr_data, st_rd_data;
    db_rsp_t st_rd_rsp;

    // Cache-corrected read response
    logic    rd_ack;
    db_rsp_t rd_rsp;

    assign app_rd_data = '{key: app_rd_key, value: '0, present: 1'b0};
    assign init_done   = db_init_done;

    db_ctrl u_ctrl (
        .clk (clk), .srst (srst),
        .ctrl_cmd_valid (ctrl_cmd_valid), .ctrl_cmd (ctrl_cmd),
        .ctrl_busy (ctrl_busy), .ctrl_done (ctrl_done), .ctrl_rsp (ctrl_rsp),
        .db_init (db_init), .db_init_done (db_init_done),
        .wr_req (ctrl_wr_req), .wr_rdy (ctrl_wr_rdy),
        .wr_data (ctrl_wr_data), .wr_ack (ctrl_wr_ack),
        .rd_req (ctrl_rd_req), .rd_rdy (ctrl_rd_rdy),
        .rd_data (ctrl_rd_data), .rd_ack (ctrl_rd_ack), .rd_rsp (ctrl_rd_rsp)
    );

    // Write path carries acks only
    db_prio_mux #(.txn_max (wr_txn_max)) u_wr_mux (
        .clk (clk), .srst (srst),
        .hi_req (app_wr_req), .hi_rdy (app_wr_rdy), .hi_data (app_wr_data),
        .hi_ack (app_wr_ack), .hi_rsp (),
        .lo_req (ctrl_wr_req), .lo_rdy (ctrl_wr_rdy), .lo_data (ctrl_wr_data),
        .lo_ack (ctrl_wr_ack), .lo_rsp (),
        .out_req (st_wr_req), .out_rdy (st_wr_rdy), .out_data (st_wr_data),
        .out_ack (st_wr_ack), .out_rsp ('0)
    );

    db_prio_mux #(.txn_max (rd_txn_max)) u_rd_mux (
        .clk (clk), .srst (srst),
        .hi_req (app_rd_req), .hi_rdy (app_rd_rdy), .hi_data (app_rd_data),
        .hi_ack (app_rd_ack), .hi_rsp (app_rd_rsp),
        .lo_req (ctrl_rd_req), .lo_rdy (ctrl_rd_rdy), .lo_data (ctrl_rd_data),
        .lo_ack (ctrl_rd_ack), .lo_rsp (ctrl_rd_rsp),
        .out_req (st_rd_req), .out_rdy (st_rd_rdy), .out_data (st_rd_data),
        .out_ack (rd_ack), .out_rsp (rd_rsp)
    );

    // Cache sees every store accept on both ports
    db_wr_cache u_cache (
        .clk (clk), .db_init (db_init),
        .wr_accept (st_wr_req && st_wr_rdy), .wr_data (st_wr_data),
        .rd_accept (st_rd_req && st_rd_rdy), .rd_key (st_rd_data.key),
        .store_ack (st_rd_ack), .store_rsp (st_rd_rsp),
        .rd_ack (rd_ack), .rd_rsp (rd_rsp)
    );

    db_store u_store (
        .clk (clk), .srst (srst),
        .db_init (db_init), .db_init_done (db_init_done),
        .wr_req (st_wr_req), .wr_rdy (st_wr_rdy),
        .wr_data (st_wr_data), .wr_ack (st_wr_ack),
        .rd_req (st_rd_req), .rd_rdy (st_rd_rdy), .rd_key (st_rd_data.key),
        .rd_ack (st_rd_ack), .rd_rsp (st_rd_rsp)
    );

endmodule

`default_nettype wire

// ==== db_ctrl.sv ====
/* Control-plane sequencer with one command in flight; strobes are dropped while busy
   INIT ends when db_init_done rises and does not pulse ctrl_done
   Requests wait for acceptance, so a busy data plane can starve them */
`timescale 1ns/1ps
`default_nettype none

module db_ctrl import db_pkg::*; (
    input  logic      clk,
    input  logic      srst,
    // Control port
    input  logic      ctrl_cmd_valid,
    input  ctrl_cmd_t ctrl_cmd,
    output logic      ctrl_busy,
    output logic      ctrl_done,
    output db_rsp_t   ctrl_rsp,
    // Table clear handshake with the store
    output logic      db_init,
    input  logic      db_init_done,
    // Low-priority write path
    output logic      wr_req,
    input  logic      wr_rdy,
    output db_req_t   wr_data,
    input  logic      wr_ack,
    // Low-priority read path
    output logic      rd_req,
    input  logic      rd_rdy,
    output db_req_t   rd_data,
    input  logic      rd_ack,
    input  db_rsp_t   rd_rsp
);

    ctrl_state_e state;
    ctrl_cmd_t   cmd_q;
    logic        cmd_take;
    logic        txn_ack;

    // New command only taken in idle
    assign cmd_take = (state == ST_IDLE) && ctrl_cmd_valid;

    // Ack of the path that the latched command went out on
    assign txn_ack = (cmd_q.op == CMD_GET) ? rd_ack : wr_ack;

    // --------------------------------------------------
    // Command FSM
    // --------------------------------------------------
    // Reset lands in ST_INIT so the table is swept before first use
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_INIT;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ctrl_cmd_valid) begin
                        case (ctrl_cmd.op)
                            CMD_INIT: state <= ST_INIT;
                            CMD_GET:  state <= ST_RD;
                            default:  state <= ST_WR;
                        endcase
                    end
                end
                // db_init_done is stale while db_init is still high
                ST_INIT: if (db_init_done && !db_init) state <= ST_IDLE;
                ST_WR:   if (wr_rdy) state <= ST_WAIT;
                ST_RD:   if (rd_rdy) state <= ST_WAIT;
                ST_WAIT: if (txn_ack) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Latched command words
    always_ff @(posedge clk) begin
        if (cmd_take) cmd_q <= ctrl_cmd;
    end

    // Held high through reset, then a one-cycle pulse per INIT
    always_ff @(posedge clk) begin
        if (srst) begin
            db_init <= 1'b1;
        end else begin
            db_init <= cmd_take && (ctrl_cmd.op == CMD_INIT);
        end
    end

    // --------------------------------------------------
    // Completion
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            ctrl_done <= 1'b0;
        end else begin
            ctrl_done <= (state == ST_WAIT) && txn_ack;
        end
    end

    // GET result, aligned with ctrl_done
    always_ff @(posedge clk) begin
        if ((state == ST_WAIT) && rd_ack) ctrl_rsp <= rd_rsp;
    end

    assign ctrl_busy = (state != ST_IDLE);

    // SET writes a present entry, DEL clears it
    assign wr_req  = (state == ST_WR);
    assign wr_data = '{key: cmd_q.key, value: cmd_q.value, present: (cmd_q.op == CMD_SET)};

    assign rd_req  = (state == ST_RD);
    assign rd_data = '{key: cmd_q.key, value: '0, present: 1'b0};

endmodule

`default_nettype wire

// ==== db_prio_mux.sv ====
/* Strict-priority mux of two requesters onto one table path; hi side always wins
   txn_max must be a power of two; acks return in acceptance order */
`timescale 1ns/1ps
`default_nettype none

module db_prio_mux import db_pkg::*; #(
    parameter int txn_max = wr_txn_max
) (
    input  logic    clk,
    input  logic    srst,
    // High-priority requester
    input  logic    hi_req,
    output logic    hi_rdy,
    input  db_req_t hi_data,
    output logic    hi_ack,
    output db_rsp_t hi_rsp,
    // Low-priority requester
    input  logic    lo_req,
    output logic    lo_rdy,
    input  db_req_t lo_data,
    output logic    lo_ack,
    output db_rsp_t lo_rsp,
    // Toward the responder
    output logic    out_req,
    input  logic    out_rdy,
    output db_req_t out_data,
    input  logic    out_ack,
    input  db_rsp_t out_rsp
);

    // Owner tags, 1 marks a low-side transaction
    logic                       tag_q [txn_max];
    logic [$clog2(txn_max)-1:0] wr_ptr;
    logic [$clog2(txn_max)-1:0] rd_ptr;
    logic [$clog2(txn_max):0]   count;
    logic                       full;
    logic                       push;
    logic                       head_lo;

    assign full = (count == txn_max);

    // --------------------------------------------------
    // Request path, purely combinational
    // --------------------------------------------------
    assign out_req  = (hi_req || lo_req) && !full;
    assign out_data = hi_req ? hi_data : lo_data;
    assign hi_rdy   = out_rdy && !full;
    // Low side only sees rdy when the high side is quiet
    assign lo_rdy   = out_rdy && !full && !hi_req;
    assign push     = out_req && out_rdy;

    // --------------------------------------------------
    // Tag queue
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) tag_q[wr_ptr] <= !hi_req;
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (out_ack) rd_ptr <= rd_ptr + 1'b1;
            case ({push, out_ack})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Ack steering by the oldest outstanding tag
    assign head_lo = tag_q[rd_ptr];
    assign hi_ack  = out_ack && !head_lo;
    assign lo_ack  = out_ack && head_lo;
    assign hi_rsp  = out_rsp;
    assign lo_rsp  = out_rsp;

endmodule

`default_nettype wire

// ==== db_wr_cache.sv ====
/* Write cache in front of the store read path; adds rsp_dly cycles to every read
   A read accepted with a write resolves before that write
   db_init clears all state; no table traffic may be in flight then */
`timescale 1ns/1ps
`default_nettype none

module db_wr_cache import db_pkg::*; (
    input  logic    clk,
    input  logic    db_init,
    // Write accepted by the store
    input  logic    wr_accept,
    input  db_req_t wr_data,
    // Read accepted by the store
    input  logic    rd_accept,
    input  key_t    rd_key,
    // Raw store read response
    input  logic    store_ack,
    input  db_rsp_t store_rsp,
    // Corrected read response
    output logic    rd_ack,
    output db_rsp_t rd_rsp
);

    // Entry 0 is the newest write
    wr_ctxt_t ctxt [wr_txn_max];
    logic     look_hit;
    db_rsp_t  look_rsp;

    // Lookup result per outstanding read
    logic                          hit_ring [rd_txn_max];
    db_rsp_t                       rsp_ring [rd_txn_max];
    logic [$clog2(rd_txn_max)-1:0] ring_wr;
    logic [$clog2(rd_txn_max)-1:0] ring_rd;

    // Store response delay line
    logic    dly_ack [rsp_dly];
    db_rsp_t dly_rsp [rsp_dly];

    // --------------------------------------------------
    // Write context line
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (db_init) begin
            for (int i = 0; i < wr_txn_max; i++) begin
                ctxt[i].used <= 1'b0;
            end
        end else if (wr_accept) begin
            for (int i = 1; i < wr_txn_max; i++) begin
                ctxt[i] <= ctxt[i-1];
            end
            ctxt[0] <= '{used: 1'b1, key: wr_data.key,
                         present: wr_data.present, value: wr_data.value};
        end
    end

    // Walk from the oldest entry so the newest match wins
    always_comb begin
        look_hit = 1'b0;
        look_rsp = '0;
        for (int i = wr_txn_max - 1; i >= 0; i--) begin
            if (ctxt[i].used && (ctxt[i].key == rd_key)) begin
                look_hit = 1'b1;
                look_rsp = '{present: ctxt[i].present, value: ctxt[i].value};
            end
        end
    end

    // --------------------------------------------------
    // Result ring
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            hit_ring[ring_wr] <= look_hit;
            rsp_ring[ring_wr] <= look_rsp;
        end
    end

    // Push at read accept, pop at the delayed ack
    always_ff @(posedge clk) begin
        if (db_init) begin
            ring_wr <= '0;
            ring_rd <= '0;
        end else begin
            if (rd_accept) ring_wr <= ring_wr + 1'b1;
            if (rd_ack) ring_rd <= ring_rd + 1'b1;
        end
    end

    // --------------------------------------------------
    // Response delay and override
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (db_init) begin
            for (int i = 0; i < rsp_dly; i++) begin
                dly_ack[i] <= 1'b0;
            end
        end else begin
            dly_ack[0] <= store_ack;
            for (int i = 1; i < rsp_dly; i++) begin
                dly_ack[i] <= dly_ack[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dly_rsp[0] <= store_rsp;
        for (int i = 1; i < rsp_dly; i++) begin
            dly_rsp[i] <= dly_rsp[i-1];
        end
    end

    assign rd_ack = dly_ack[rsp_dly-1];

    // Cached write beats a store read that missed it
    always_comb begin
        rd_rsp = dly_rsp[rsp_dly-1];
        if (rd_ack && hit_ring[ring_rd]) rd_rsp = rsp_ring[ring_rd];
    end

endmodule

`default_nettype wire

// ==== db_store.sv ====
/* Table store with fixed store_lat latency on both ports and no stalls outside init
   A write commits when it is acked, so reads of recent writes need the cache
   Writes still in the pipe when db_init rises are acked but not kept */
`timescale 1ns/1ps
`default_nettype none

module db_store import db_pkg::*; (
    input  logic    clk,
    input  logic    srst,
    input  logic    db_init,
    output logic    db_init_done,
    // Write port
    input  logic    wr_req,
    output logic    wr_rdy,
    input  db_req_t wr_data,
    output logic    wr_ack,
    // Read port
    input  logic    rd_req,
    output logic    rd_rdy,
    input  key_t    rd_key,
    output logic    rd_ack,
    output db_rsp_t rd_rsp
);

    db_rsp_t mem [tbl_depth];
    logic    sweep_on;
    key_t    sweep_idx;

    logic    wr_vld  [store_lat];
    db_req_t wr_pipe [store_lat];
    logic    rd_vld  [store_lat];
    db_rsp_t rd_pipe [store_lat];

    // No traffic while init is requested or the sweep runs
    assign wr_rdy = !db_init && !sweep_on;
    assign rd_rdy = !db_init && !sweep_on;

    // --------------------------------------------------
    // Clear sweep
    // --------------------------------------------------
    // One entry per cycle once db_init has fallen
    always_ff @(posedge clk) begin
        if (srst || db_init) begin
            sweep_on     <= 1'b1;
            sweep_idx    <= '0;
            db_init_done <= 1'b0;
        end else if (sweep_on && (sweep_idx == key_t'(tbl_depth - 1))) begin
            sweep_on     <= 1'b0;
            db_init_done <= 1'b1;
        end else if (sweep_on) begin
            sweep_idx <= sweep_idx + 1'b1;
        end
    end

    // Sweep owns the write port while it runs
    always_ff @(posedge clk) begin
        if (sweep_on) begin
            mem[sweep_idx] <= '0;
        end else if (wr_vld[store_lat-1]) begin
            mem[wr_pipe[store_lat-1].key] <= '{present: wr_pipe[store_lat-1].present,
                                               value: wr_pipe[store_lat-1].value};
        end
    end

    // --------------------------------------------------
    // Latency pipes
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < store_lat; i++) begin
                wr_vld[i] <= 1'b0;
                rd_vld[i] <= 1'b0;
            end
        end else begin
            wr_vld[0] <= wr_req && wr_rdy;
            rd_vld[0] <= rd_req && rd_rdy;
            for (int i = 1; i < store_lat; i++) begin
                wr_vld[i] <= wr_vld[i-1];
                rd_vld[i] <= rd_vld[i-1];
            end
        end
    end

    // Read data is sampled at acceptance
    always_ff @(posedge clk) begin
        wr_pipe[0] <= wr_data;
        rd_pipe[0] <= mem[rd_key];
        for (int i = 1; i < store_lat; i++) begin
            wr_pipe[i] <= wr_pipe[i-1];
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign wr_ack = wr_vld[store_lat-1];
    assign rd_ack = rd_vld[store_lat-1];
    assign rd_rsp = rd_pipe[store_lat-1];

endmodule

`default_nettype wire

// ==== db_pkg.sv ====
/* Shared sizes, latencies and types of the key-value table subsystem
   One entry per key, so every key_t value is a legal table index */
`default_nettype none

package db_pkg;

    // --------------------------------------------------
    // Table geometry
    // --------------------------------------------------
    localparam int key_w     = 8;
    localparam int value_w   = 16;
    localparam int tbl_depth = 256;

    // --------------------------------------------------
    // Latencies and in-flight limits
    // --------------------------------------------------
    // Accept to ack inside the store, reads and writes alike
    localparam int store_lat  = 3;
    // Extra read latency added by the cache lookup
    localparam int rsp_dly    = 2;
    // Cache entries, also the write mux in-flight limit
    localparam int wr_txn_max = 4;
    localparam int rd_txn_max = 8;

    typedef logic [key_w-1:0]   key_t;
    typedef logic [value_w-1:0] value_t;

    // Request words of a table transaction
    // present is 0 for a delete; reads use key only
    typedef struct packed {
        key_t   key;
        value_t value;
        logic   present;
    } db_req_t;

    // Read result, valid with ack
    typedef struct packed {
        logic   present;
        value_t value;
    } db_rsp_t;

    // One write cache entry
    typedef struct packed {
        logic   used;
        key_t   key;
        logic   present;
        value_t value;
    } wr_ctxt_t;

    typedef enum logic [1:0] {
        CMD_GET,
        CMD_SET,
        CMD_DEL,
        CMD_INIT
    } ctrl_op_e;

    typedef struct packed {
        ctrl_op_e op;
        key_t     key;
        value_t   value;
    } ctrl_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT,
        ST_WR,
        ST_RD,
        ST_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire
